/* rtl/video_consts.svh */
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// source raster, counted in source pixels (one per two clk_hdmi cycles)
`define VDP_H_ACTIVE      256
`define VDP_H_TOTAL       342

// source raster, counted in source lines
`define VDP_V_ACTIVE      192
`define VDP_V_TOTAL       262

// hsync pulse, in source pixels from the start of the line
`define VDP_H_SYNC_START  280
`define VDP_H_SYNC_LEN    26

// vsync pulse, in source lines from the top of the frame
`define VDP_V_SYNC_START  216
`define VDP_V_SYNC_LEN    3

// line memory address, must cover VDP_H_TOTAL entries
`define LINE_ADDR_W       9

`endif

/* rtl/video_pkg.sv */
`default_nettype none

package video_pkg;

   // TMS9918 colour indices
   typedef enum logic [3:0] {
      TRANSPARENT  = 4'd0,
      BLACK        = 4'd1,
      MEDIUM_GREEN = 4'd2,
      LIGHT_GREEN  = 4'd3,
      DARK_BLUE    = 4'd4,
      LIGHT_BLUE   = 4'd5,
      DARK_RED     = 4'd6,
      CYAN         = 4'd7,
      MEDIUM_RED   = 4'd8,
      LIGHT_RED    = 4'd9,
      DARK_YELLOW  = 4'd10,
      LIGHT_YELLOW = 4'd11,
      DARK_GREEN   = 4'd12,
      MAGENTA      = 4'd13,
      GRAY         = 4'd14,
      WHITE        = 4'd15
   } tms_color_e;

   typedef struct packed {
      logic       hsync;
      logic       vsync;
      logic       de;      // active video
      tms_color_e color;
   } pixel_t;

   typedef struct packed {
      logic [7:0] r;
      logic [7:0] g;
      logic [7:0] b;
   } rgb_t;

   // [9:0] blue, [19:10] green, [29:20] red
   typedef logic [29:0] tmds_word_t;

   typedef enum logic {
      FIRST_PASS  = 1'b0,
      SECOND_PASS = 1'b1
   } dbl_phase_e;

endpackage

`default_nettype wire

/* rtl/vdp_raster_gen.sv */
`timescale 1ns/10ps
`default_nettype none
`include "video_consts.svh"

module vdp_raster_gen import video_pkg::*; (
   input  logic   clk_hdmi,
   input  logic   arst_n_i,
   output pixel_t src_pix_o,
   output logic   src_stb_o
);

   logic [`LINE_ADDR_W-1:0] h_cnt;
   logic [8:0]              v_cnt;
   logic                    stb_q;
   logic                    active;
   pixel_t                  pix_d;

   // half rate pixel enable
   always_ff @(posedge clk_hdmi or negedge arst_n_i) begin
      if (!arst_n_i)
         stb_q <= 1'b0;
      else
         stb_q <= ~stb_q;
   end

   assign src_stb_o = stb_q;

   always_ff @(posedge clk_hdmi or negedge arst_n_i) begin
      if (!arst_n_i) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else if (stb_q) begin
         if (h_cnt == `LINE_ADDR_W'(`VDP_H_TOTAL - 1)) begin
            h_cnt <= '0;
            if (v_cnt == 9'(`VDP_V_TOTAL - 1))
               v_cnt <= '0;
            else
               v_cnt <= v_cnt + 9'd1;
         end else begin
            h_cnt <= h_cnt + 1'b1;
         end
      end
   end

   assign active = (h_cnt < `LINE_ADDR_W'(`VDP_H_ACTIVE)) && (v_cnt < 9'(`VDP_V_ACTIVE));

   always_comb begin
      pix_d.de    = active;
      pix_d.hsync = (h_cnt >= `LINE_ADDR_W'(`VDP_H_SYNC_START)) &&
                    (h_cnt < `LINE_ADDR_W'(`VDP_H_SYNC_START + `VDP_H_SYNC_LEN));
      pix_d.vsync = (v_cnt >= 9'(`VDP_V_SYNC_START)) &&
                    (v_cnt < 9'(`VDP_V_SYNC_START + `VDP_V_SYNC_LEN));
      // diagonal stripes, 16 pixels wide, shifted one index per line
      if (active)
         pix_d.color = tms_color_e'(h_cnt[7:4] + v_cnt[3:0]);
      else
         pix_d.color = TRANSPARENT;
   end

   always_ff @(posedge clk_hdmi or negedge arst_n_i) begin
      if (!arst_n_i)
         src_pix_o <= '0;
      else if (stb_q)
         src_pix_o <= pix_d;
   end

endmodule

`default_nettype wire

/* rtl/line_doubler.sv */
`timescale 1ns/10ps
`default_nettype none
`include "video_consts.svh"

module line_doubler import video_pkg::*; (
   input  logic   clk_hdmi,
   input  logic   arst_n_i,
   input  pixel_t src_pix_i,
   input  logic   src_stb_i,
   output pixel_t dbl_pix_o
);

   localparam logic [`LINE_ADDR_W-1:0] LAST_ADDR = `LINE_ADDR_W'(`VDP_H_TOTAL - 1);

   pixel_t line_mem [0:1][0:`VDP_H_TOTAL-1];

   logic                    wr_bank;
   logic [`LINE_ADDR_W-1:0] wr_addr;
   logic                    filled;    // one complete line is in memory
   logic                    new_line;

   logic                    rd_bank;
   logic [`LINE_ADDR_W-1:0] rd_addr;
   logic                    rd_run;
   dbl_phase_e              phase;

   assign new_line = src_stb_i && (wr_addr == '0);

   // write side, source rate
   always_ff @(posedge clk_hdmi) begin
      if (src_stb_i)
         line_mem[wr_bank][wr_addr] <= src_pix_i;
   end

   always_ff @(posedge clk_hdmi or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_bank <= 1'b0;
         wr_addr <= '0;
         filled  <= 1'b0;
      end else if (src_stb_i) begin
         if (wr_addr == LAST_ADDR) begin
            wr_addr <= '0;
            wr_bank <= ~wr_bank;
            filled  <= 1'b1;
         end else begin
            wr_addr <= wr_addr + 1'b1;
         end
      end
   end

   // read side, full rate, the finished bank twice
   always_ff @(posedge clk_hdmi or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rd_bank <= 1'b0;
         rd_addr <= '0;
         rd_run  <= 1'b0;
         phase   <= FIRST_PASS;
      end else if (new_line) begin
         rd_bank <= ~wr_bank;   // wr_bank already flipped
         rd_addr <= '0;
         rd_run  <= filled;
         phase   <= FIRST_PASS;
      end else if (rd_addr == LAST_ADDR) begin
         rd_addr <= '0;
         phase   <= SECOND_PASS;
         if (phase == SECOND_PASS)
            rd_run <= 1'b0;     // source stalled, blank until next line
      end else begin
         rd_addr <= rd_addr + 1'b1;
      end
   end

   always_ff @(posedge clk_hdmi or negedge arst_n_i) begin
      if (!arst_n_i)
         dbl_pix_o <= '0;
      else if (rd_run)
         dbl_pix_o <= line_mem[rd_bank][rd_addr];
      else
         dbl_pix_o <= '0;
   end

endmodule

`default_nettype wire

/* rtl/tmds_channel_encoder.sv */
`timescale 1ns/10ps
`default_nettype none

module tmds_channel_encoder (
   input  logic       clk_hdmi,
   input  logic       arst_n_i,
   input  logic [7:0] data_i,
   input  logic [1:0] ctrl_i,   // {c1, c0}
   input  logic       de_i,
   output logic [9:0] sym_o
);

   // transition minimising stage, bit 8 set when xor was used
   function automatic logic [8:0] min_trans(input logic [7:0] d);
      logic [3:0] ones;
      logic       xnor_sel;
      logic [8:0] q;
      ones = 4'($countones(d));
      xnor_sel = (ones > 4'd4) || ((ones == 4'd4) && !d[0]);
      q[0] = d[0];
      for (int i = 1; i < 8; i++)
         q[i] = xnor_sel ? ~(q[i-1] ^ d[i]) : (q[i-1] ^ d[i]);
      q[8] = ~xnor_sel;
      return q;
   endfunction

   logic [8:0]        q_m;
   logic [3:0]        n1_q;
   logic signed [5:0] bal;     // ones minus zeros in q_m[7:0]
   logic signed [5:0] cnt_q;
   logic signed [5:0] cnt_d;
   logic [9:0]        sym_d;
   logic [9:0]        ctrl_sym;

   assign q_m  = min_trans(data_i);
   assign n1_q = 4'($countones(q_m[7:0]));
   assign bal  = $signed({1'b0, n1_q, 1'b0}) - 6'sd8;

   always_comb begin
      if ((cnt_q == 6'sd0) || (bal == 6'sd0)) begin
         sym_d = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
         cnt_d = q_m[8] ? cnt_q + bal : cnt_q - bal;
      end else if (((cnt_q > 6'sd0) && (bal > 6'sd0)) ||
                   ((cnt_q < 6'sd0) && (bal < 6'sd0))) begin
         sym_d = {1'b1, q_m[8], ~q_m[7:0]};
         cnt_d = cnt_q - bal + (q_m[8] ? 6'sd2 : 6'sd0);
      end else begin
         sym_d = {1'b0, q_m[8], q_m[7:0]};
         cnt_d = cnt_q + bal - (q_m[8] ? 6'sd0 : 6'sd2);
      end
   end

   always_comb begin
      case (ctrl_i)
         2'b00:   ctrl_sym = 10'b1101010100;
         2'b01:   ctrl_sym = 10'b0010101011;
         2'b10:   ctrl_sym = 10'b0101010100;
         default: ctrl_sym = 10'b1010101011;
      endcase
   end

   always_ff @(posedge clk_hdmi or negedge arst_n_i) begin
      if (!arst_n_i) begin
         sym_o <= 10'b1101010100;
         cnt_q <= '0;
      end else if (!de_i) begin
         sym_o <= ctrl_sym;
         cnt_q <= '0;   // disparity restarts each active period
      end else begin
         sym_o <= sym_d;
         cnt_q <= cnt_d;
      end
   end

endmodule

`default_nettype wire

/* rtl/dvi_encoder.sv */
`timescale 1ns/10ps
`default_nettype none

module dvi_encoder import video_pkg::*; (
   input  logic       clk_hdmi,
   input  logic       arst_n_i,
   input  pixel_t     pix_i,
   input  tms_color_e overlay_color_i,
   output tmds_word_t tmds_o
);

   function automatic rgb_t tms_palette(input tms_color_e c);
      case (c)
         TRANSPARENT:  return '{8'h00, 8'h00, 8'h00};
         BLACK:        return '{8'h00, 8'h00, 8'h00};
         MEDIUM_GREEN: return '{8'h21, 8'hc8, 8'h42};
         LIGHT_GREEN:  return '{8'h5e, 8'hdc, 8'h78};
         DARK_BLUE:    return '{8'h54, 8'h55, 8'hed};
         LIGHT_BLUE:   return '{8'h7d, 8'h76, 8'hfc};
         DARK_RED:     return '{8'hd4, 8'h52, 8'h4d};
         CYAN:         return '{8'h42, 8'heb, 8'hf5};
         MEDIUM_RED:   return '{8'hfc, 8'h55, 8'h54};
         LIGHT_RED:    return '{8'hff, 8'h79, 8'h78};
         DARK_YELLOW:  return '{8'hd4, 8'hc1, 8'h54};
         LIGHT_YELLOW: return '{8'he6, 8'hce, 8'h80};
         DARK_GREEN:   return '{8'h21, 8'hb0, 8'h3b};
         MAGENTA:      return '{8'hc9, 8'h5b, 8'hba};
         GRAY:         return '{8'hcc, 8'hcc, 8'hcc};
         default:      return '{8'hff, 8'hff, 8'hff};
      endcase
   endfunction

   tms_color_e color_sel;
   rgb_t       rgb_q;
   logic       hs_q;
   logic       vs_q;
   logic       de_q;
   logic [9:0] sym_b;
   logic [9:0] sym_g;
   logic [9:0] sym_r;

   // overlay wins unless transparent
   assign color_sel = (overlay_color_i != TRANSPARENT) ? overlay_color_i : pix_i.color;

   always_ff @(posedge clk_hdmi) begin
      rgb_q <= tms_palette(color_sel);
   end

   always_ff @(posedge clk_hdmi or negedge arst_n_i) begin
      if (!arst_n_i) begin
         hs_q <= 1'b0;
         vs_q <= 1'b0;
         de_q <= 1'b0;
      end else begin
         hs_q <= pix_i.hsync;
         vs_q <= pix_i.vsync;
         de_q <= pix_i.de;
      end
   end

   tmds_channel_encoder enc_b (
      .clk_hdmi (clk_hdmi),
      .arst_n_i (arst_n_i),
      .data_i   (rgb_q.b),
      .ctrl_i   ({vs_q, hs_q}),   // c0 carries hsync
      .de_i     (de_q),
      .sym_o    (sym_b)
   );

   tmds_channel_encoder enc_g (
      .clk_hdmi (clk_hdmi),
      .arst_n_i (arst_n_i),
      .data_i   (rgb_q.g),
      .ctrl_i   (2'b00),
      .de_i     (de_q),
      .sym_o    (sym_g)
   );

   tmds_channel_encoder enc_r (
      .clk_hdmi (clk_hdmi),
      .arst_n_i (arst_n_i),
      .data_i   (rgb_q.r),
      .ctrl_i   (2'b00),
      .de_i     (de_q),
      .sym_o    (sym_r)
   );

   assign tmds_o = {sym_r, sym_g, sym_b};

endmodule

`default_nettype wire

/* rtl/video_hdmi_top.sv */
`timescale 1ns/10ps
`default_nettype none

module video_hdmi_top import video_pkg::*; (
   input  logic       clk_hdmi,
   input  logic       arst_n_i,
   input  tms_color_e overlay_color_i,
   output tmds_word_t tmds_o
);

   pixel_t src_pix;
   logic   src_stb;
   pixel_t dbl_pix;

   vdp_raster_gen vdp (
      .clk_hdmi  (clk_hdmi),
      .arst_n_i  (arst_n_i),
      .src_pix_o (src_pix),
      .src_stb_o (src_stb)
   );

   line_doubler scandoubler (
      .clk_hdmi  (clk_hdmi),
      .arst_n_i  (arst_n_i),
      .src_pix_i (src_pix),
      .src_stb_i (src_stb),
      .dbl_pix_o (dbl_pix)
   );

   dvi_encoder hdmi_encoder (
      .clk_hdmi        (clk_hdmi),
      .arst_n_i        (arst_n_i),
      .pix_i           (dbl_pix),
      .overlay_color_i (overlay_color_i),
      .tmds_o          (tmds_o)
   );

endmodule

`default_nettype wire

/* verification/tb_video_hdmi.sv */
`timescale 1ns/10ps
`default_nettype none
`include "video_consts.svh"

module tb_video_hdmi import video_pkg::*; ();

   localparam int    CLK_PERIOD = 8;
   localparam int    LAST_FRAME = 2;   // frames 0 and 2 show the pattern, frame 1 the overlay
   localparam longint WATCHDOG_CYCLES =
      3 * `VDP_V_TOTAL * 2 * `VDP_H_TOTAL + 8 * 2 * `VDP_H_TOTAL;

   typedef struct packed {
      logic       is_ctrl;
      logic       legal;
      logic [1:0] ctrl;   // {vsync, hsync} on channel 0
      logic [7:0] data;
   } sym_dec_t;

   logic       clk_hdmi;
   logic       arst_n_i;
   tms_color_e overlay_color_i;
   tmds_word_t tmds_o;

   logic [15:0] lfsr_q = 16'd2;
   int          de_run = 0;
   int          since_de = 0;
   int          hs_len = 0;
   int          out_line = 0;
   int          vs_lines = 0;
   int          blank_lines = 0;
   int          frame = 0;
   int          disp [3] = '{0, 0, 0};
   logic        prev_de = 1'b0;
   logic        prev_hs = 1'b0;
   logic        had_de = 1'b0;
   logic        in_vblank = 1'b0;
   logic        done = 1'b0;
   tms_color_e  frame_overlay = TRANSPARENT;

   video_hdmi_top dut (
      .clk_hdmi        (clk_hdmi),
      .arst_n_i        (arst_n_i),
      .overlay_color_i (overlay_color_i),
      .tmds_o          (tmds_o)
   );

   initial begin
      clk_hdmi = 1'b0;
      forever #(CLK_PERIOD / 2) clk_hdmi = ~clk_hdmi;
   end

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16 + x^14 + x^13 + x^11 + 1
   endfunction

   task automatic draw_bits(input int n, output logic [15:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[14:0], lfsr_q[15]};
         lfsr_q = lfsr_next(lfsr_q);
      end
   endtask

   function automatic rgb_t palette_rgb(input int idx);
      case (idx)
         0, 1:    return 24'h000000;
         2:       return 24'h21c842;
         3:       return 24'h5edc78;
         4:       return 24'h5455ed;
         5:       return 24'h7d76fc;
         6:       return 24'hd4524d;
         7:       return 24'h42ebf5;
         8:       return 24'hfc5554;
         9:       return 24'hff7978;
         10:      return 24'hd4c154;
         11:      return 24'he6ce80;
         12:      return 24'h21b03b;
         13:      return 24'hc95bba;
         14:      return 24'hcccccc;
         default: return 24'hffffff;
      endcase
   endfunction

   // expected colour of source pixel x on source line y
   function automatic rgb_t ref_rgb(input int x, input int y, input tms_color_e ov);
      int idx;
      if (ov != TRANSPARENT)
         idx = int'(ov);
      else
         idx = (x / 16 + y) % 16;
      return palette_rgb(idx);
   endfunction

   function automatic sym_dec_t decode_tmds(input logic [9:0] s);
      sym_dec_t   r;
      logic [7:0] q;
      logic       xnor_sel;
      int         ones;
      r = '0;
      r.legal = 1'b1;
      case (s)
         10'b1101010100: r.is_ctrl = 1'b1;
         10'b0010101011: begin r.is_ctrl = 1'b1; r.ctrl = 2'b01; end
         10'b0101010100: begin r.is_ctrl = 1'b1; r.ctrl = 2'b10; end
         10'b1010101011: begin r.is_ctrl = 1'b1; r.ctrl = 2'b11; end
         default: begin
            q = s[9] ? ~s[7:0] : s[7:0];
            r.data[0] = q[0];
            for (int i = 1; i < 8; i++)
               r.data[i] = s[8] ? (q[i] ^ q[i-1]) : ~(q[i] ^ q[i-1]);
            ones = $countones(r.data);
            xnor_sel = (ones > 4) || ((ones == 4) && !r.data[0]);
            r.legal = (s[8] != xnor_sel);   // bit 8 must match the minimising choice
         end
      endcase
      return r;
   endfunction

   task automatic abort_run();
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic report_failure(input string why);
      $display("%0t: %s", $time, why);
      abort_run();
   endtask

   task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
      if (got !== exp) begin
         $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_ctrl(input string name, input logic [1:0] got, input logic [1:0] exp);
      if (got !== exp) begin
         $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp) begin
         $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_reset_idle();
      sym_dec_t d;
      for (int c = 0; c < 3; c++) begin
         d = decode_tmds(tmds_o[c*10 +: 10]);
         if (!d.is_ctrl)
            report_failure($sformatf("channel %0d sends data around reset", c));
         check_ctrl($sformatf("tmds ch%0d ctrl around reset", c), d.ctrl, 2'b00);
      end
   endtask

   initial begin : stimulus
      logic [15:0] pick;
      arst_n_i = 1'b0;
      overlay_color_i = TRANSPARENT;
      repeat (8) begin
         @(negedge clk_hdmi);
         check_reset_idle();
      end
      arst_n_i = 1'b1;
      // doubler holds one source line, so the output stays idle for a while
      repeat (8) begin
         @(negedge clk_hdmi);
         check_reset_idle();
      end
      pick = '0;
      while (pick[3:0] == 4'd0)
         draw_bits(4, pick);
      wait (frame == 1);   // first vblank seen
      @(negedge clk_hdmi);
      overlay_color_i = tms_color_e'(pick[3:0]);
      wait (frame == 2);
      @(negedge clk_hdmi);
      overlay_color_i = TRANSPARENT;
      wait (done);
      @(negedge clk_hdmi);
      $display("all tests passed");
      $finish;
   end

   initial begin : watchdog
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("timeout: three frames were not seen within %0d clock cycles", WATCHDOG_CYCLES);
      abort_run();
   end

   // outputs only move on the rising edge, so sample on the falling one
   always @(negedge clk_hdmi) begin : compare_proc
      sym_dec_t d [3];
      rgb_t     got;
      for (int c = 0; c < 3; c++) begin
         d[c] = decode_tmds(tmds_o[c*10 +: 10]);
         if (!d[c].legal)
            report_failure($sformatf("illegal TMDS symbol %b on channel %0d",
                                     tmds_o[c*10 +: 10], c));
      end
      if (d[0].is_ctrl) begin
         if (!d[1].is_ctrl || !d[2].is_ctrl)
            report_failure("channels disagree on data enable");
         check_ctrl("tmds ch1 ctrl", d[1].ctrl, 2'b00);
         check_ctrl("tmds ch2 ctrl", d[2].ctrl, 2'b00);
         for (int c = 0; c < 3; c++)
            disp[c] = 0;
         if (prev_de) begin
            check_count("de pixels per line", de_run, `VDP_H_ACTIVE);
            out_line++;
            if (frame == LAST_FRAME && out_line == 2 * `VDP_V_ACTIVE)
               done = 1'b1;
         end
         if (d[0].ctrl[0]) begin
            if (!prev_hs) begin
               if (had_de) begin
                  check_count("hsync offset after de", since_de,
                              `VDP_H_SYNC_START - `VDP_H_ACTIVE);
                  blank_lines = 0;
               end
               hs_len = 0;
               if (d[0].ctrl[1]) begin
                  vs_lines++;
                  if (!in_vblank) begin
                     check_count("active lines per frame", out_line, 2 * `VDP_V_ACTIVE);
                     check_count("blank lines before vsync", blank_lines,
                                 2 * (`VDP_V_SYNC_START - `VDP_V_ACTIVE));
                     in_vblank = 1'b1;
                     out_line = 0;
                     frame++;
                  end
               end
               if (!had_de)
                  blank_lines++;
               had_de = 1'b0;
            end
            hs_len++;
         end else if (prev_hs) begin
            check_count("hsync width", hs_len, `VDP_H_SYNC_LEN);
         end
         since_de++;
         prev_hs = d[0].ctrl[0];
         prev_de = 1'b0;
      end else begin
         if (d[1].is_ctrl || d[2].is_ctrl)
            report_failure("channels disagree on data enable");
         if (!prev_de) begin
            if (in_vblank) begin
               check_count("vsync lines", vs_lines, 2 * `VDP_V_SYNC_LEN);
               in_vblank = 1'b0;
               vs_lines = 0;
            end
            de_run = 0;
            if (out_line == 0)
               frame_overlay = overlay_color_i;
         end
         got = {d[2].data, d[1].data, d[0].data};
         check_rgb("tmds rgb", got, ref_rgb(de_run, out_line / 2, frame_overlay));
         for (int c = 0; c < 3; c++) begin
            disp[c] += 2 * $countones(tmds_o[c*10 +: 10]) - 10;
            if (disp[c] > 10 || disp[c] < -10)
               report_failure($sformatf("running disparity %0d out of range on channel %0d",
                                        disp[c], c));
         end
         de_run++;
         since_de = 0;
         had_de = 1'b1;
         prev_hs = 1'b0;
         prev_de = 1'b1;
      end
   end

endmodule

`default_nettype wire

/* sim.f */
+incdir+rtl
rtl/video_pkg.sv
rtl/vdp_raster_gen.sv
rtl/line_doubler.sv
rtl/tmds_channel_encoder.sv
rtl/dvi_encoder.sv
rtl/video_hdmi_top.sv
verification/tb_video_hdmi.sv

/* run_sim.sh */
#!/bin/sh
# build and run the video path testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -j 0 --top-module tb_video_hdmi -f sim.f -o tb_video_hdmi

./obj_dir/tb_video_hdmi > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "^all tests passed$" "$LOG"; then
   echo "PASS"
   exit 0
else
   echo "FAIL"
   exit 1
fi
